/* flist.f */
receive_pkg.sv
sample_conditioner.sv
sample_discriminator.sv
sample_buffer.sv
receive_top.sv
receive_top_tb.sv

/* Makefile */
TOP = receive_top_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* receive_top_tb.sv */
// testbench for the receive path: case table, LFSR stimulus,
// reference model of the framed readout and word checks
`timescale 1ns/10ps
module receive_top_tb;

  localparam int num_cases = 6;
  localparam int max_beats = 100;
  localparam int timeout_cycles = 5000;

  typedef struct packed {
    logic [1:0] mode;
    int thr_high;
    int thr_low;
    int range_lo;
    int range_hi;
    int beats;
    bit random_ready;
    int summary;
  } case_t;

  // mode, high, low, range lo/hi, beats, random ready, summary (-1 leaves it to the model)
  case_t cases [num_cases] = '{
    '{2'b00, 100, 50, 200, 1000, 10, 1'b0, 20},
    '{2'b00, 0, 0, -1000, -10, 12, 1'b0, 0},
    '{2'b00, 500, -500, -2000, 2000, 40, 1'b0, -1},
    '{2'b11, -100, -20000, -3000, 3000, 30, 1'b0, -1},
    '{2'b01, 500, -500, -2000, 2000, 40, 1'b1, -1},
    '{2'b00, -1, -2, 0, 30000, 100, 1'b0, 128}
  };

  logic clk;
  logic reset;
  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] adc_data;
  logic [receive_pkg::channels-1:0] adc_valid;
  logic [receive_pkg::channels-1:0] source_mode;
  logic mux_cfg_valid;
  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] threshold_high;
  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] threshold_low;
  logic disc_cfg_valid;
  logic capture_start;
  logic capture_stop;
  logic [receive_pkg::beat_width-1:0] dma_data;
  logic dma_header;
  logic [receive_pkg::channel_width-1:0] dma_channel;
  logic dma_last;
  logic dma_valid;
  logic dma_ready;

  logic [31:0] lfsr;
  logic [receive_pkg::beat_width-1:0] sent [receive_pkg::channels][max_beats];
  // last sample of each channel seen by the conditioner, kept across cases
  logic [receive_pkg::sample_width-1:0] ref_last [receive_pkg::channels];
  logic [31:0] exp_data [$];
  // {last, header, channel}
  logic [2:0] exp_flags [$];
  int errors;
  int words_checked;
  bit timed_out;

  receive_top i_receive_top (
    .clk(clk),
    .reset(reset),
    .adc_data(adc_data),
    .adc_valid(adc_valid),
    .source_mode(source_mode),
    .mux_cfg_valid(mux_cfg_valid),
    .threshold_high(threshold_high),
    .threshold_low(threshold_low),
    .disc_cfg_valid(disc_cfg_valid),
    .capture_start(capture_start),
    .capture_stop(capture_stop),
    .dma_data(dma_data),
    .dma_header(dma_header),
    .dma_channel(dma_channel),
    .dma_last(dma_last),
    .dma_valid(dma_valid),
    .dma_ready(dma_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic make_beats(input int k);
    logic [31:0] r;
    int span;
    span = cases[k].range_hi - cases[k].range_lo + 1;
    for (int b = 0; b < cases[k].beats; b++) begin
      for (int c = 0; c < receive_pkg::channels; c++) begin
        for (int s = 0; s < receive_pkg::parallel_samples; s++) begin
          take_bits(16, r);
          sent[c][b][s*16 +: 16] = 16'(cases[k].range_lo + int'(r) % span);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [15:0] half_diff(input logic [15:0] cur, input logic [15:0] prv);
    int d;
    d = int'($signed(cur)) - int'($signed(prv));
    return 16'(d >>> 1);
  endfunction

  task automatic build_expected(input int k);
    logic [31:0] beat;
    logic [15:0] prv;
    logic signed [15:0] smp;
    logic armed;
    logic pending;
    logic any_above;
    logic all_below;
    int n_data;
    int n_seg;
    int total;
    exp_data.delete();
    exp_flags.delete();
    total = 0;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      armed = 1'b0;
      pending = 1'b1;
      n_data = 0;
      n_seg = 0;
      for (int b = 0; b < cases[k].beats; b++) begin
        any_above = 1'b0;
        all_below = 1'b1;
        for (int s = 0; s < receive_pkg::parallel_samples; s++) begin
          prv = (s == 0) ? ref_last[c] : sent[c][b][(s-1)*16 +: 16];
          smp = cases[k].mode[c] ? half_diff(sent[c][b][s*16 +: 16], prv)
                                 : sent[c][b][s*16 +: 16];
          beat[s*16 +: 16] = smp;
          if (int'(smp) > cases[k].thr_high) any_above = 1'b1;
          if (int'(smp) >= cases[k].thr_low) all_below = 1'b0;
        end
        ref_last[c] = sent[c][b][31:16];
        if (any_above) armed = 1'b1;
        else if (all_below) armed = 1'b0;
        // a full channel drops the beat, segment mark included
        if (armed && n_data < receive_pkg::data_depth && n_seg < receive_pkg::tstamp_depth) begin
          if (pending) begin
            exp_data.push_back(32'(b));
            exp_flags.push_back({1'b0, 1'b1, 1'(c)});
            n_seg++;
          end
          exp_data.push_back(beat);
          exp_flags.push_back({1'b0, 1'b0, 1'(c)});
          n_data++;
          total++;
        end
        pending = !armed;
      end
    end
    exp_data.push_back(32'(total));
    exp_flags.push_back(3'b100);
  endtask

  //////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////
  task automatic configure(input int k);
    @(posedge clk);
    source_mode <= cases[k].mode;
    mux_cfg_valid <= 1'b1;
    disc_cfg_valid <= 1'b1;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      threshold_high[c] <= 16'(cases[k].thr_high);
      threshold_low[c] <= 16'(cases[k].thr_low);
    end
    @(posedge clk);
    mux_cfg_valid <= 1'b0;
    disc_cfg_valid <= 1'b0;
    capture_start <= 1'b1;
    @(posedge clk);
    capture_start <= 1'b0;
  endtask

  task automatic send_beats(input int k);
    for (int b = 0; b < cases[k].beats; b++) begin
      @(posedge clk);
      for (int c = 0; c < receive_pkg::channels; c++) begin
        adc_data[c] <= sent[c][b];
      end
      adc_valid <= '1;
    end
    @(posedge clk);
    adc_valid <= '0;
  endtask

  task automatic check_word(input int k, input int idx);
    assert (idx < exp_data.size()) else begin
      errors++;
      $display("case %0d: extra word %0d after the %0d expected words", k, idx, exp_data.size());
    end
    if (idx < exp_data.size()) begin
      assert (dma_data == exp_data[idx]) else begin
        errors++;
        $display("mismatch dma_data case %0d word %0d: got %h expected %h",
          k, idx, dma_data, exp_data[idx]);
      end
      assert (dma_header == exp_flags[idx][1]) else begin
        errors++;
        $display("mismatch dma_header case %0d word %0d: got %h expected %h",
          k, idx, dma_header, exp_flags[idx][1]);
      end
      assert (dma_last == exp_flags[idx][2]) else begin
        errors++;
        $display("mismatch dma_last case %0d word %0d: got %h expected %h",
          k, idx, dma_last, exp_flags[idx][2]);
      end
      if (!exp_flags[idx][2]) begin
        assert (dma_channel == exp_flags[idx][0]) else begin
          errors++;
          $display("mismatch dma_channel case %0d word %0d: got %h expected %h",
            k, idx, dma_channel, exp_flags[idx][0]);
        end
      end
    end
    // summary values known without the model
    if (dma_last && cases[k].summary >= 0) begin
      assert (dma_data == 32'(cases[k].summary)) else begin
        errors++;
        $display("mismatch dma_data summary case %0d: got %h expected %h",
          k, dma_data, 32'(cases[k].summary));
      end
    end
  endtask

  task automatic collect_words(input int k);
    logic [31:0] r;
    int idx;
    int cycles;
    bit done;
    idx = 0;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
      if (dma_valid && dma_ready) begin
        check_word(k, idx);
        words_checked++;
        done = dma_last;
        idx++;
      end
      if (cases[k].random_ready) begin
        take_bits(1, r);
        dma_ready <= r[0];
      end
    end
    dma_ready <= 1'b1;
    if (!done) begin
      errors++;
      timed_out = 1'b1;
      $display("case %0d: no summary word within %0d cycles", k, timeout_cycles);
    end else begin
      assert (idx == exp_data.size()) else begin
        errors++;
        $display("case %0d: readout ended after %0d words, %0d expected",
          k, idx, exp_data.size());
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    adc_data = '0;
    adc_valid = '0;
    source_mode = '0;
    mux_cfg_valid = 1'b0;
    threshold_high = '0;
    threshold_low = '0;
    disc_cfg_valid = 1'b0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    dma_ready = 1'b1;
    lfsr = 32'd91225;
    errors = 0;
    words_checked = 0;
    timed_out = 1'b0;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      ref_last[c] = '0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (int k = 0; k < num_cases && !timed_out; k++) begin
      configure(k);
      make_beats(k);
      build_expected(k);
      send_beats(k);
      // let the last beat reach the memory
      repeat (4) @(posedge clk);
      capture_stop <= 1'b1;
      @(posedge clk);
      capture_stop <= 1'b0;
      collect_words(k);
    end
    $display("errors: %0d, words checked: %0d", errors, words_checked);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* receive_top.sv */
// receive path top level: conditioner, discriminator and buffer
`timescale 1ns/10ps
module receive_top (
  input  logic clk,
  input  logic reset,
  input  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] adc_data,
  input  logic [receive_pkg::channels-1:0] adc_valid,
  input  logic [receive_pkg::channels-1:0] source_mode,
  input  logic mux_cfg_valid,
  input  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] threshold_high,
  input  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] threshold_low,
  input  logic disc_cfg_valid,
  input  logic capture_start,
  input  logic capture_stop,
  output logic [receive_pkg::beat_width-1:0] dma_data,
  output logic dma_header,
  output logic [receive_pkg::channel_width-1:0] dma_channel,
  output logic dma_last,
  output logic dma_valid,
  input  logic dma_ready
);

  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] cond_data;
  logic [receive_pkg::channels-1:0] cond_valid;
  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] keep_data;
  logic [receive_pkg::channels-1:0] keep_valid;
  logic [receive_pkg::channels-1:0] keep_segment_start;
  logic [receive_pkg::channels-1:0][receive_pkg::timestamp_width-1:0] keep_timestamp;

  sample_conditioner i_sample_conditioner (
    .clk(clk),
    .reset(reset),
    .adc_data(adc_data),
    .adc_valid(adc_valid),
    .source_mode(source_mode),
    .mux_cfg_valid(mux_cfg_valid),
    .cond_data(cond_data),
    .cond_valid(cond_valid)
  );

  sample_discriminator i_sample_discriminator (
    .clk(clk),
    .reset(reset),
    .cond_data(cond_data),
    .cond_valid(cond_valid),
    .threshold_high(threshold_high),
    .threshold_low(threshold_low),
    .disc_cfg_valid(disc_cfg_valid),
    .capture_start(capture_start),
    .keep_data(keep_data),
    .keep_valid(keep_valid),
    .keep_segment_start(keep_segment_start),
    .keep_timestamp(keep_timestamp)
  );

  sample_buffer i_sample_buffer (
    .clk(clk),
    .reset(reset),
    .keep_data(keep_data),
    .keep_valid(keep_valid),
    .keep_segment_start(keep_segment_start),
    .keep_timestamp(keep_timestamp),
    .capture_start(capture_start),
    .capture_stop(capture_stop),
    .dma_ready(dma_ready),
    .dma_data(dma_data),
    .dma_header(dma_header),
    .dma_channel(dma_channel),
    .dma_last(dma_last),
    .dma_valid(dma_valid)
  );

endmodule

/* sample_buffer.sv */
// per-channel data and timestamp memories, capture control
// and the framed readout stream
`timescale 1ns/10ps
module sample_buffer (
  input  logic clk,
  input  logic reset,
  input  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] keep_data,
  input  logic [receive_pkg::channels-1:0] keep_valid,
  input  logic [receive_pkg::channels-1:0] keep_segment_start,
  input  logic [receive_pkg::channels-1:0][receive_pkg::timestamp_width-1:0] keep_timestamp,
  input  logic capture_start,
  input  logic capture_stop,
  input  logic dma_ready,
  output logic [receive_pkg::beat_width-1:0] dma_data,
  output logic dma_header,
  output logic [receive_pkg::channel_width-1:0] dma_channel,
  output logic dma_last,
  output logic dma_valid
);

  // segment start flag sits above the beat in each data entry
  logic [receive_pkg::beat_width:0] data_mem [receive_pkg::channels][receive_pkg::data_depth];
  logic [receive_pkg::timestamp_width-1:0] ts_mem [receive_pkg::channels][receive_pkg::tstamp_depth];
  logic [receive_pkg::channels-1:0][receive_pkg::data_addr_width:0] data_wr;
  logic [receive_pkg::channels-1:0][receive_pkg::tstamp_addr_width:0] ts_wr;
  logic [receive_pkg::channels-1:0] store;
  logic capturing;

  receive_pkg::read_state_t rd_state;
  logic [receive_pkg::channel_width-1:0] rd_ch;
  logic [receive_pkg::data_addr_width:0] data_rd;
  logic [receive_pkg::tstamp_addr_width:0] ts_rd;
  logic [receive_pkg::beat_width-1:0] word_count;
  logic [receive_pkg::beat_width:0] rd_entry;

  // a channel stops storing once either memory is full
  always_comb begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      store[c] = capturing && keep_valid[c] && !data_wr[c][receive_pkg::data_addr_width]
        && !ts_wr[c][receive_pkg::tstamp_addr_width];
    end
  end

  assign rd_entry = data_mem[rd_ch][data_rd[receive_pkg::data_addr_width-1:0]];

  always_ff @(posedge clk) begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      if (store[c]) begin
        data_mem[c][data_wr[c][receive_pkg::data_addr_width-1:0]] <=
          {keep_segment_start[c], keep_data[c]};
        if (keep_segment_start[c]) begin
          ts_mem[c][ts_wr[c][receive_pkg::tstamp_addr_width-1:0]] <= keep_timestamp[c];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // capture control and readout sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      capturing <= 1'b0;
      data_wr <= '0;
      ts_wr <= '0;
      rd_state <= receive_pkg::rd_idle;
      dma_valid <= 1'b0;
      dma_last <= 1'b0;
    end else begin
      for (int c = 0; c < receive_pkg::channels; c++) begin
        if (store[c]) begin
          data_wr[c] <= data_wr[c] + 1'b1;
          if (keep_segment_start[c]) begin
            ts_wr[c] <= ts_wr[c] + 1'b1;
          end
        end
      end
      case (rd_state)
        receive_pkg::rd_idle: begin
          if (capture_start) begin
            capturing <= 1'b1;
            data_wr <= '0;
            ts_wr <= '0;
          end
          if (capture_stop) begin
            capturing <= 1'b0;
            rd_ch <= '0;
            data_rd <= '0;
            ts_rd <= '0;
            word_count <= '0;
            rd_state <= receive_pkg::rd_next;
          end
        end
        receive_pkg::rd_next: begin
          if (data_rd != data_wr[rd_ch]) begin
            dma_valid <= 1'b1;
            dma_channel <= rd_ch;
            if (rd_entry[receive_pkg::beat_width]) begin
              dma_data <= ts_mem[rd_ch][ts_rd[receive_pkg::tstamp_addr_width-1:0]];
              dma_header <= 1'b1;
              ts_rd <= ts_rd + 1'b1;
              rd_state <= receive_pkg::rd_header;
            end else begin
              dma_data <= rd_entry[receive_pkg::beat_width-1:0];
              dma_header <= 1'b0;
              rd_state <= receive_pkg::rd_data;
            end
          end else if (rd_ch == receive_pkg::channel_width'(receive_pkg::channels - 1)) begin
            // all channels drained, emit the word count and free both memories
            dma_valid <= 1'b1;
            dma_last <= 1'b1;
            dma_header <= 1'b0;
            dma_data <= word_count;
            data_wr <= '0;
            ts_wr <= '0;
            rd_state <= receive_pkg::rd_summary;
          end else begin
            rd_ch <= rd_ch + 1'b1;
            data_rd <= '0;
            ts_rd <= '0;
          end
        end
        receive_pkg::rd_header: begin
          if (dma_ready) begin
            dma_data <= rd_entry[receive_pkg::beat_width-1:0];
            dma_header <= 1'b0;
            rd_state <= receive_pkg::rd_data;
          end
        end
        receive_pkg::rd_data: begin
          if (dma_ready) begin
            dma_valid <= 1'b0;
            data_rd <= data_rd + 1'b1;
            word_count <= word_count + 1'b1;
            rd_state <= receive_pkg::rd_next;
          end
        end
        receive_pkg::rd_summary: begin
          if (dma_ready) begin
            dma_valid <= 1'b0;
            dma_last <= 1'b0;
            rd_state <= receive_pkg::rd_idle;
          end
        end
        default: rd_state <= receive_pkg::rd_idle;
      endcase
    end
  end

endmodule

/* sample_discriminator.sv */
// per-channel hysteresis keep decision, beat index counter
// and segment start marking
`timescale 1ns/10ps
module sample_discriminator (
  input  logic clk,
  input  logic reset,
  input  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] cond_data,
  input  logic [receive_pkg::channels-1:0] cond_valid,
  input  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] threshold_high,
  input  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] threshold_low,
  input  logic disc_cfg_valid,
  input  logic capture_start,
  output logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] keep_data,
  output logic [receive_pkg::channels-1:0] keep_valid,
  output logic [receive_pkg::channels-1:0] keep_segment_start,
  output logic [receive_pkg::channels-1:0][receive_pkg::timestamp_width-1:0] keep_timestamp
);

  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] thr_high;
  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] thr_low;
  receive_pkg::disc_state_t state [receive_pkg::channels];
  receive_pkg::disc_state_t next_state [receive_pkg::channels];
  logic [receive_pkg::channels-1:0][receive_pkg::timestamp_width-1:0] beat_index;
  // high from capture start or a dropped beat up to the next kept beat
  logic [receive_pkg::channels-1:0] seg_pending;

  //////////////////////////////////////////////////
  // hysteresis
  //////////////////////////////////////////////////
  always_comb begin
    logic any_above;
    logic all_below;
    logic signed [receive_pkg::sample_width-1:0] smp;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      any_above = 1'b0;
      all_below = 1'b1;
      for (int s = 0; s < receive_pkg::parallel_samples; s++) begin
        smp = cond_data[c][s*receive_pkg::sample_width +: receive_pkg::sample_width];
        if (smp > $signed(thr_high[c])) begin
          any_above = 1'b1;
        end
        if (smp >= $signed(thr_low[c])) begin
          all_below = 1'b0;
        end
      end
      if (any_above) begin
        next_state[c] = receive_pkg::disc_armed;
      end else if (all_below) begin
        next_state[c] = receive_pkg::disc_idle;
      end else begin
        next_state[c] = state[c];
      end
    end
  end

  //////////////////////////////////////////////////
  // state, counters and keep strobe
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      thr_high <= '0;
      thr_low <= '0;
      keep_valid <= '0;
      seg_pending <= '1;
      beat_index <= '0;
      for (int c = 0; c < receive_pkg::channels; c++) begin
        state[c] <= receive_pkg::disc_idle;
      end
    end else begin
      if (disc_cfg_valid) begin
        thr_high <= threshold_high;
        thr_low <= threshold_low;
      end
      for (int c = 0; c < receive_pkg::channels; c++) begin
        keep_valid[c] <= 1'b0;
        if (capture_start) begin
          state[c] <= receive_pkg::disc_idle;
          beat_index[c] <= '0;
          seg_pending[c] <= 1'b1;
        end else if (cond_valid[c]) begin
          state[c] <= next_state[c];
          beat_index[c] <= beat_index[c] + 1'b1;
          keep_valid[c] <= (next_state[c] == receive_pkg::disc_armed);
          seg_pending[c] <= (next_state[c] != receive_pkg::disc_armed);
        end
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      if (cond_valid[c]) begin
        keep_data[c] <= cond_data[c];
        keep_timestamp[c] <= beat_index[c];
        keep_segment_start[c] <= seg_pending[c];
      end
    end
  end

endmodule

/* sample_conditioner.sv */
// per-channel halved first difference and raw/difference source select
`timescale 1ns/10ps
module sample_conditioner (
  input  logic clk,
  input  logic reset,
  input  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] adc_data,
  input  logic [receive_pkg::channels-1:0] adc_valid,
  input  logic [receive_pkg::channels-1:0] source_mode,
  input  logic mux_cfg_valid,
  output logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] cond_data,
  output logic [receive_pkg::channels-1:0] cond_valid
);

  receive_pkg::source_mode_t mode [receive_pkg::channels];
  // last sample of the previous valid beat
  logic [receive_pkg::channels-1:0][receive_pkg::sample_width-1:0] last_sample;
  logic [receive_pkg::channels-1:0][receive_pkg::beat_width-1:0] diff_beat;

  always_comb begin
    logic [receive_pkg::sample_width-1:0] cur;
    logic [receive_pkg::sample_width-1:0] prv;
    logic [receive_pkg::sample_width:0] delta;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      for (int s = 0; s < receive_pkg::parallel_samples; s++) begin
        cur = adc_data[c][s*receive_pkg::sample_width +: receive_pkg::sample_width];
        if (s == 0) begin
          prv = last_sample[c];
        end else begin
          prv = adc_data[c][(s-1)*receive_pkg::sample_width +: receive_pkg::sample_width];
        end
        // one extra sign bit keeps the difference exact, dropping the lsb halves it
        delta = {cur[receive_pkg::sample_width-1], cur} - {prv[receive_pkg::sample_width-1], prv};
        diff_beat[c][s*receive_pkg::sample_width +: receive_pkg::sample_width] =
          delta[receive_pkg::sample_width:1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cond_valid <= '0;
      last_sample <= '0;
      for (int c = 0; c < receive_pkg::channels; c++) begin
        mode[c] <= receive_pkg::src_raw;
      end
    end else begin
      cond_valid <= adc_valid;
      for (int c = 0; c < receive_pkg::channels; c++) begin
        if (mux_cfg_valid) begin
          mode[c] <= receive_pkg::source_mode_t'(source_mode[c]);
        end
        if (adc_valid[c]) begin
          last_sample[c] <= adc_data[c][receive_pkg::beat_width-1 -: receive_pkg::sample_width];
        end
      end
    end
  end

  // output register
  always_ff @(posedge clk) begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      if (adc_valid[c]) begin
        cond_data[c] <= (mode[c] == receive_pkg::src_diff) ? diff_beat[c] : adc_data[c];
      end
    end
  end

endmodule

/* receive_pkg.sv */
// widths, depths, channel count and state/mode encodings
// shared by the two-channel ADC receive path
package receive_pkg;

  //////////////////////////////////////////////////
  // stream sizes
  //////////////////////////////////////////////////
  localparam int channels = 2;
  localparam int channel_width = $clog2(channels);
  localparam int parallel_samples = 2;
  localparam int sample_width = 16;
  localparam int beat_width = parallel_samples * sample_width;
  localparam int timestamp_width = 32;

  //////////////////////////////////////////////////
  // per-channel memories
  //////////////////////////////////////////////////
  // write pointers are one bit wider than the address so that full shows in the msb
  localparam int data_depth = 64;
  localparam int data_addr_width = $clog2(data_depth);
  localparam int tstamp_depth = 32;
  localparam int tstamp_addr_width = $clog2(tstamp_depth);

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////
  typedef enum logic {
    src_raw,
    src_diff
  } source_mode_t;

  typedef enum logic {
    disc_idle,
    disc_armed
  } disc_state_t;

  // readout sequencer
  typedef enum logic [2:0] {
    rd_idle,
    rd_header,
    rd_data,
    rd_summary,
    rd_next
  } read_state_t;

endpackage
